// ==== icache_pkg.sv ====
// shared geometry, address fields and array payload types of the instruction cache
// every cache module refers to these by scoped names

package icache_pkg;

  ////////////////////////////////
  // geometry
  ////////////////////////////////

  // physical byte address and fetch word
  localparam int unsigned ADDR_W  = 32;
  localparam int unsigned FETCH_W = 32;
  // one line holds four fetch words
  localparam int unsigned LINE_W  = 128;
  localparam int unsigned WAYS    = 4;
  localparam int unsigned SETS    = 16;
  // address split: tag | index | offset
  localparam int unsigned OFF_W   = 4;
  localparam int unsigned IDX_W   = 4;
  localparam int unsigned TAG_W   = ADDR_W - IDX_W - OFF_W;
  localparam int unsigned WAY_W   = 2;
  // top half of the address space is i/o, never cached
  localparam int unsigned NC_BIT  = 31;

  ////////////////////////////////
  // types
  ////////////////////////////////

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [TAG_W-1:0]  tag_t;
  typedef logic [IDX_W-1:0]  idx_t;
  typedef logic [OFF_W-1:0]  off_t;
  typedef logic [LINE_W-1:0] line_t;
  typedef logic [WAYS-1:0]   way_oh_t;
  typedef logic [WAY_W-1:0]  way_t;

  // fills and invalidations share the return channel
  typedef enum logic {
    RTRN_IFILL = 1'b0,
    RTRN_INV   = 1'b1
  } rtrn_type_e;

  // tag array payload, valid bit on top
  typedef struct packed {
    logic vld;
    tag_t tag;
  } tag_entry_t;

  // binary way number to one-hot way enable
  function automatic way_oh_t way_bin2oh(way_t way);
    way_oh_t oh;
    oh      = '0;
    oh[way] = 1'b1;
    return oh;
  endfunction

endpackage

// ==== icache_sram.sv ====
// single-port array with one-cycle read latency
// holds either the tag entries or the lines of one way
`timescale 1ns/1ps

module icache_sram #(
  parameter type         word_t = icache_pkg::line_t,
  parameter int unsigned DEPTH  = icache_pkg::SETS
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             req_i,
  input  logic             we_i,
  input  icache_pkg::idx_t addr_i,
  input  word_t            wdata_i,
  output word_t            rdata_o
);

  word_t mem_q [DEPTH];

  // storage clears on reset so every tag entry starts invalid
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem_q[i] <= '0;
      end
      rdata_o <= '0;
    end else if (req_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        // read data stays put until the next read
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

// ==== icache_repl.sv ====
// victim way selection for a refill
// first invalid way, otherwise a pseudo-random way from an lfsr
`timescale 1ns/1ps

module icache_repl (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  icache_pkg::way_oh_t vld_i,
  input  logic                advance_i,
  output icache_pkg::way_t    way_o
);

  logic [7:0]       lfsr_q;
  logic             lfsr_fb;
  logic             all_vld;
  icache_pkg::way_t inv_way;

  // lowest numbered invalid way, scan from the top so the lowest wins
  always_comb begin
    inv_way = '0;
    for (int w = icache_pkg::WAYS - 1; w >= 0; w--) begin
      if (!vld_i[w]) begin
        inv_way = icache_pkg::way_t'(w);
      end
    end
  end

  assign all_vld = &vld_i;

  // x^8 + x^6 + x^5 + x^4 + 1, maximal length
  assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

  assign way_o = all_vld ? lfsr_q[icache_pkg::WAY_W-1:0] : inv_way;

  // only steps when a fill actually evicts a valid line
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= 8'ha5;
    end else if (advance_i && all_vld) begin
      lfsr_q <= {lfsr_q[6:0], lfsr_fb};
    end
  end

endmodule

// ==== icache_hit.sv ====
// tag compare over all ways and fetch word select
// word comes from the hit line, or from the return line on a refill
`timescale 1ns/1ps

module icache_hit (
  input  icache_pkg::tag_entry_t        tags_i [icache_pkg::WAYS],
  input  icache_pkg::line_t             lines_i [icache_pkg::WAYS],
  input  icache_pkg::tag_t              tag_i,
  input  icache_pkg::off_t              off_i,
  input  icache_pkg::line_t             rtrn_data_i,
  input  logic                          use_cache_i,
  output logic                          hit_o,
  output icache_pkg::way_oh_t           hit_way_o,
  output logic [icache_pkg::FETCH_W-1:0] data_o
);

  // word number inside the line, byte bits dropped
  logic [icache_pkg::OFF_W-3:0] word_sel;

  assign word_sel = off_i[icache_pkg::OFF_W-1:2];

  for (genvar w = 0; w < icache_pkg::WAYS; w++) begin : gen_cmp
    assign hit_way_o[w] = tags_i[w].vld && (tags_i[w].tag == tag_i);
  end

  // compare result only counts when the lookup is cacheable
  assign hit_o = use_cache_i & (|hit_way_o);

  always_comb begin
    data_o = '0;
    if (use_cache_i) begin
      // and-or mux over the one-hot hit vector
      for (int w = 0; w < icache_pkg::WAYS; w++) begin
        if (hit_way_o[w]) begin
          data_o = data_o | lines_i[w][word_sel * icache_pkg::FETCH_W +: icache_pkg::FETCH_W];
        end
      end
    end else begin
      // nc fills carry the word at its own offset as well
      data_o = rtrn_data_i[word_sel * icache_pkg::FETCH_W +: icache_pkg::FETCH_W];
    end
  end

  // a line is never allocated twice in one set
  always_comb begin
    assert final ($onehot0(hit_way_o))
      else $error("icache: tag found in more than one way");
  end

endmodule

// ==== icache_ctrl.sv ====
// controller of the instruction cache: lookup FSM, refill and nc requests,
// flush walk, invalidations, and the enables and addresses of all arrays
`timescale 1ns/1ps

module icache_ctrl (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // fetch request and response
  input  logic                           req_valid_i,
  input  icache_pkg::addr_t              req_addr_i,
  output logic                           req_ready_o,
  output logic                           rsp_valid_o,
  output logic [icache_pkg::FETCH_W-1:0] rsp_data_o,
  // control
  input  logic                           flush_i,
  input  logic                           en_i,
  output logic                           miss_o,
  // memory request
  output logic                           mem_req_valid_o,
  input  logic                           mem_req_ready_i,
  output icache_pkg::addr_t              mem_req_addr_o,
  output logic                           mem_req_nc_o,
  output icache_pkg::way_t               mem_req_way_o,
  // memory return, line data goes straight to the arrays
  input  logic                           mem_rtrn_valid_i,
  input  icache_pkg::rtrn_type_e         mem_rtrn_type_i,
  input  icache_pkg::idx_t               mem_rtrn_inv_idx_i,
  input  logic                           mem_rtrn_inv_all_i,
  input  icache_pkg::way_t               mem_rtrn_inv_way_i,
  // tag arrays
  output icache_pkg::way_oh_t            tag_req_o,
  output logic                           tag_we_o,
  output icache_pkg::idx_t               tag_addr_o,
  output icache_pkg::tag_entry_t         tag_wdata_o,
  input  icache_pkg::tag_entry_t         tag_rdata_i [icache_pkg::WAYS],
  // data arrays
  output icache_pkg::way_oh_t            data_req_o,
  output logic                           data_we_o,
  output icache_pkg::idx_t               data_addr_o,
  // compare logic
  input  logic                           hit_i,
  input  logic [icache_pkg::FETCH_W-1:0] hit_word_i,
  output icache_pkg::tag_t               tag_o,
  output icache_pkg::off_t               off_o,
  output logic                           use_cache_o,
  // replacement
  input  icache_pkg::way_t               repl_way_i,
  output logic                           repl_advance_o
);

  typedef enum logic [1:0] {FLUSH, IDLE, READ, MISS} state_e;

  state_e            state_d, state_q;
  icache_pkg::addr_t addr_q;
  icache_pkg::idx_t  flush_cnt_d, flush_cnt_q;
  icache_pkg::idx_t  rd_idx;
  icache_pkg::way_t  repl_way_q;
  logic              cache_en_d, cache_en_q;
  logic              flush_d, flush_q;
  logic              inv_en, inv_q;
  logic              run_q;
  logic              accept, nc;
  logic              rd_en, fill_en, flush_en, flush_done;

  //////////////////////////////
  // address plumbing
  //////////////////////////////

  assign accept = req_valid_i & req_ready_o;
  // lookup index, fills reuse the registered one
  assign rd_idx = accept ? req_addr_i[icache_pkg::OFF_W +: icache_pkg::IDX_W]
                         : addr_q[icache_pkg::OFF_W +: icache_pkg::IDX_W];

  assign tag_o = addr_q[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];
  assign off_o = addr_q[icache_pkg::OFF_W-1:0];

  // i/o space or a disabled cache goes around the arrays
  assign nc          = ~cache_en_q | addr_q[icache_pkg::NC_BIT];
  assign use_cache_o = (state_q == READ) & ~nc;
  assign rsp_data_o  = hit_word_i;

  // nc reads are word sized, refills are whole lines
  assign mem_req_addr_o = nc ? {addr_q[icache_pkg::ADDR_W-1:2], 2'b00}
                             : {addr_q[icache_pkg::ADDR_W-1:icache_pkg::OFF_W],
                                {icache_pkg::OFF_W{1'b0}}};
  assign mem_req_nc_o   = nc;
  // tag read data is held while the request waits, so the victim is stable
  assign mem_req_way_o  = repl_way_i;

  assign inv_en = mem_rtrn_valid_i & (mem_rtrn_type_i == icache_pkg::RTRN_INV);

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_comb begin
    state_d         = state_q;
    cache_en_d      = cache_en_q;
    flush_d         = flush_q | flush_i;
    req_ready_o     = 1'b0;
    rsp_valid_o     = 1'b0;
    mem_req_valid_o = 1'b0;
    miss_o          = 1'b0;
    rd_en           = 1'b0;
    fill_en         = 1'b0;
    flush_en        = 1'b0;

    unique case (state_q)
      // walk all sets and clear every valid bit
      FLUSH: begin
        flush_en = 1'b1;
        if (flush_done) begin
          state_d    = IDLE;
          flush_d    = 1'b0;
          cache_en_d = en_i;
        end
      end
      // disable takes effect here, enable goes through a flush
      IDLE: begin
        cache_en_d = cache_en_q & en_i;
        if (flush_d || (en_i && !cache_en_q)) begin
          state_d = FLUSH;
        end else if (run_q && !mem_rtrn_valid_i) begin
          // a valid return would need the tag port
          req_ready_o = 1'b1;
          if (req_valid_i) begin
            rd_en   = 1'b1;
            state_d = READ;
          end
        end
      end
      // arrays are out, decide hit or miss
      READ: begin
        if (inv_q) begin
          // tags may be stale, look again
          rd_en = 1'b1;
        end else if (hit_i) begin
          rsp_valid_o = 1'b1;
          cache_en_d  = cache_en_q & en_i;
          state_d     = IDLE;
          // back to back lookup unless a flush is pending
          if (!mem_rtrn_valid_i && !flush_d) begin
            req_ready_o = 1'b1;
            if (req_valid_i) begin
              rd_en   = 1'b1;
              state_d = READ;
            end
          end
        end else begin
          // miss, or nc access through the same path
          mem_req_valid_o = 1'b1;
          if (mem_req_ready_i) begin
            miss_o  = ~nc;
            state_d = MISS;
          end
        end
      end
      // wait for the fill, nc data is not written
      MISS: begin
        if (mem_rtrn_valid_i && mem_rtrn_type_i == icache_pkg::RTRN_IFILL) begin
          rsp_valid_o = 1'b1;
          fill_en     = ~nc;
          state_d     = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  //////////////////////////////
  // flush walk and arrays
  //////////////////////////////

  assign flush_done  = (flush_cnt_q == icache_pkg::idx_t'(icache_pkg::SETS - 1));
  assign flush_cnt_d = !flush_en  ? flush_cnt_q :
                       flush_done ? '0          :
                                    flush_cnt_q + 1'b1;

  // flush over invalidation over fill and lookup
  assign tag_addr_o  = flush_en ? flush_cnt_q        :
                       inv_en   ? mem_rtrn_inv_idx_i :
                                  rd_idx;
  assign tag_we_o    = flush_en | inv_en | fill_en;
  assign tag_wdata_o = '{vld: fill_en, tag: tag_o};

  always_comb begin
    if (flush_en) begin
      tag_req_o = '1;
    end else if (inv_en) begin
      tag_req_o = mem_rtrn_inv_all_i ? '1 : icache_pkg::way_bin2oh(mem_rtrn_inv_way_i);
    end else if (fill_en) begin
      tag_req_o = icache_pkg::way_bin2oh(repl_way_q);
    end else begin
      tag_req_o = rd_en ? '1 : '0;
    end
  end

  // line data only moves on lookups and fills
  assign data_addr_o = rd_idx;
  assign data_we_o   = fill_en;
  assign data_req_o  = rd_en   ? '1                                  :
                       fill_en ? icache_pkg::way_bin2oh(repl_way_q)  :
                                 '0;

  assign repl_advance_o = fill_en;

  //////////////////////////////
  // registers
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= req_addr_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      cache_en_q  <= 1'b0;
      flush_q     <= 1'b0;
      inv_q       <= 1'b0;
      flush_cnt_q <= '0;
      repl_way_q  <= '0;
      run_q       <= 1'b0;
    end else begin
      state_q     <= state_d;
      cache_en_q  <= cache_en_d;
      flush_q     <= flush_d;
      // a raised memory request is already committed to its miss
      inv_q       <= inv_en & ~mem_req_valid_o;
      flush_cnt_q <= flush_cnt_d;
      run_q       <= 1'b1;
      // victim for the coming fill
      if (state_q == READ) begin
        repl_way_q <= repl_way_i;
      end
    end
  end

  a_state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {FLUSH, IDLE, READ, MISS})
    else $error("icache: controller in illegal state");

  // fill, invalidation and flush walk share the tag port
  a_fill_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fill_en |-> !(inv_en || flush_en))
    else $error("icache: fill collides with invalidation or flush");

endmodule

// ==== icache_top.sv ====
// four-way set-associative instruction cache, top level
// ties the tag and line arrays to the controller, compare and replacement logic
`timescale 1ns/1ps

module icache_top (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // fetch request and response
  input  logic                           req_valid_i,
  input  icache_pkg::addr_t              req_addr_i,
  output logic                           req_ready_o,
  output logic                           rsp_valid_o,
  output logic [icache_pkg::FETCH_W-1:0] rsp_data_o,
  // control
  input  logic                           flush_i,
  input  logic                           en_i,
  output logic                           miss_o,
  // memory request
  output logic                           mem_req_valid_o,
  input  logic                           mem_req_ready_i,
  output icache_pkg::addr_t              mem_req_addr_o,
  output logic                           mem_req_nc_o,
  output icache_pkg::way_t               mem_req_way_o,
  // memory return
  input  logic                           mem_rtrn_valid_i,
  input  icache_pkg::rtrn_type_e         mem_rtrn_type_i,
  input  icache_pkg::line_t              mem_rtrn_data_i,
  input  icache_pkg::idx_t               mem_rtrn_inv_idx_i,
  input  logic                           mem_rtrn_inv_all_i,
  input  icache_pkg::way_t               mem_rtrn_inv_way_i
);

  // tag array side
  icache_pkg::way_oh_t           tag_req;
  logic                          tag_we;
  icache_pkg::idx_t              tag_addr;
  icache_pkg::tag_entry_t        tag_wdata;
  icache_pkg::tag_entry_t        tag_rdata [icache_pkg::WAYS];
  icache_pkg::way_oh_t           way_vld;
  // line array side
  icache_pkg::way_oh_t           data_req;
  logic                          data_we;
  icache_pkg::idx_t              data_addr;
  icache_pkg::line_t             line_rdata [icache_pkg::WAYS];
  // compare and replacement
  logic                          hit;
  logic [icache_pkg::FETCH_W-1:0] hit_word;
  icache_pkg::tag_t              cmp_tag;
  icache_pkg::off_t              cmp_off;
  logic                          use_cache;
  icache_pkg::way_t              repl_way;
  logic                          repl_advance;

  icache_ctrl i_ctrl (
    .clk_i              ( clk_i              ),
    .rst_ni             ( rst_ni             ),
    .req_valid_i        ( req_valid_i        ),
    .req_addr_i         ( req_addr_i         ),
    .req_ready_o        ( req_ready_o        ),
    .rsp_valid_o        ( rsp_valid_o        ),
    .rsp_data_o         ( rsp_data_o         ),
    .flush_i            ( flush_i            ),
    .en_i               ( en_i               ),
    .miss_o             ( miss_o             ),
    .mem_req_valid_o    ( mem_req_valid_o    ),
    .mem_req_ready_i    ( mem_req_ready_i    ),
    .mem_req_addr_o     ( mem_req_addr_o     ),
    .mem_req_nc_o       ( mem_req_nc_o       ),
    .mem_req_way_o      ( mem_req_way_o      ),
    .mem_rtrn_valid_i   ( mem_rtrn_valid_i   ),
    .mem_rtrn_type_i    ( mem_rtrn_type_i    ),
    .mem_rtrn_inv_idx_i ( mem_rtrn_inv_idx_i ),
    .mem_rtrn_inv_all_i ( mem_rtrn_inv_all_i ),
    .mem_rtrn_inv_way_i ( mem_rtrn_inv_way_i ),
    .tag_req_o          ( tag_req            ),
    .tag_we_o           ( tag_we             ),
    .tag_addr_o         ( tag_addr           ),
    .tag_wdata_o        ( tag_wdata          ),
    .tag_rdata_i        ( tag_rdata          ),
    .data_req_o         ( data_req           ),
    .data_we_o          ( data_we            ),
    .data_addr_o        ( data_addr          ),
    .hit_i              ( hit                ),
    .hit_word_i         ( hit_word           ),
    .tag_o              ( cmp_tag            ),
    .off_o              ( cmp_off            ),
    .use_cache_o        ( use_cache          ),
    .repl_way_i         ( repl_way           ),
    .repl_advance_o     ( repl_advance       )
  );

  // the one-hot hit vector is only needed inside the compare block
  icache_hit i_hit (
    .tags_i      ( tag_rdata       ),
    .lines_i     ( line_rdata      ),
    .tag_i       ( cmp_tag         ),
    .off_i       ( cmp_off         ),
    .rtrn_data_i ( mem_rtrn_data_i ),
    .use_cache_i ( use_cache       ),
    .hit_o       ( hit             ),
    .hit_way_o   (                 ),
    .data_o      ( hit_word        )
  );

  icache_repl i_repl (
    .clk_i     ( clk_i        ),
    .rst_ni    ( rst_ni       ),
    .vld_i     ( way_vld      ),
    .advance_i ( repl_advance ),
    .way_o     ( repl_way     )
  );

  for (genvar w = 0; w < icache_pkg::WAYS; w++) begin : gen_way
    // tag plus valid bit
    icache_sram #(
      .word_t ( icache_pkg::tag_entry_t ),
      .DEPTH  ( icache_pkg::SETS        )
    ) i_tag_sram (
      .clk_i   ( clk_i        ),
      .rst_ni  ( rst_ni       ),
      .req_i   ( tag_req[w]   ),
      .we_i    ( tag_we       ),
      .addr_i  ( tag_addr     ),
      .wdata_i ( tag_wdata    ),
      .rdata_o ( tag_rdata[w] )
    );

    // line data, written from the return channel
    icache_sram #(
      .word_t ( icache_pkg::line_t ),
      .DEPTH  ( icache_pkg::SETS   )
    ) i_data_sram (
      .clk_i   ( clk_i           ),
      .rst_ni  ( rst_ni          ),
      .req_i   ( data_req[w]     ),
      .we_i    ( data_we         ),
      .addr_i  ( data_addr       ),
      .wdata_i ( mem_rtrn_data_i ),
      .rdata_o ( line_rdata[w]   )
    );

    assign way_vld[w] = tag_rdata[w].vld;
  end

endmodule

// ==== tb_icache.sv ====
// testbench for the instruction cache: memory model, cache reference model and in-order checker
// directed tests first, then random fetches over a few sets
`timescale 1ns/1ps

module tb_icache;

  localparam int unsigned N_RAND = 300;

  logic                           clk_i;
  logic                           rst_ni;
  logic                           req_valid_i;
  icache_pkg::addr_t              req_addr_i;
  logic                           req_ready_o;
  logic                           rsp_valid_o;
  logic [icache_pkg::FETCH_W-1:0] rsp_data_o;
  logic                           flush_i;
  logic                           en_i;
  logic                           miss_o;
  logic                           mem_req_valid_o;
  logic                           mem_req_ready_i;
  icache_pkg::addr_t              mem_req_addr_o;
  logic                           mem_req_nc_o;
  icache_pkg::way_t               mem_req_way_o;
  logic                           mem_rtrn_valid_i;
  icache_pkg::rtrn_type_e         mem_rtrn_type_i;
  icache_pkg::line_t              mem_rtrn_data_i;
  icache_pkg::idx_t               mem_rtrn_inv_idx_i;
  logic                           mem_rtrn_inv_all_i;
  icache_pkg::way_t               mem_rtrn_inv_way_i;

  // reference model of the tag arrays
  logic             mdl_vld [icache_pkg::SETS][icache_pkg::WAYS];
  icache_pkg::tag_t mdl_tag [icache_pkg::SETS][icache_pkg::WAYS];
  icache_pkg::way_t way_of [icache_pkg::addr_t];
  // accepted fetches in order, with the request count expected at their response
  icache_pkg::addr_t pend_addr [$];
  int                pend_reqs [$];
  icache_pkg::addr_t last_addr;
  logic              last_nc;
  int issued, req_count, miss_count, data_errs, bus_errs;

  icache_top i_dut (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #20 clk_i = ~clk_i;
    end
  end

  //////////////////////////////
  // reference functions
  //////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // memory content, a fixed hash of the word address
  function automatic logic [31:0] mem_word(input icache_pkg::addr_t a);
    logic [31:0] w;
    w = {a[31:2], 2'b00};
    w = w ^ (w >> 13) ^ 32'h5bd1_e995;
    return w * 32'h0001_9e37 + {w[15:0], w[31:16]};
  endfunction

  function automatic icache_pkg::line_t line_data(input icache_pkg::addr_t base);
    icache_pkg::line_t l;
    for (int k = 0; k < 4; k++) begin
      l[k*32 +: 32] = mem_word(base + icache_pkg::addr_t'(4 * k));
    end
    return l;
  endfunction

  function automatic logic line_cached(input icache_pkg::addr_t a);
    icache_pkg::idx_t idx;
    icache_pkg::tag_t tag;
    logic             hit;
    idx = a[icache_pkg::OFF_W +: icache_pkg::IDX_W];
    tag = a[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];
    hit = 1'b0;
    for (int w = 0; w < icache_pkg::WAYS; w++) begin
      if (mdl_vld[idx][w] && mdl_tag[idx][w] == tag) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  task automatic drop_model_lines();
    for (int s = 0; s < icache_pkg::SETS; s++) begin
      for (int w = 0; w < icache_pkg::WAYS; w++) begin
        mdl_vld[s][w] = 1'b0;
      end
    end
  endtask

  //////////////////////////////
  // memory model
  //////////////////////////////

  initial begin : memory_model
    logic [31:0]       mem_seed;
    icache_pkg::addr_t req_addr;
    icache_pkg::idx_t  idx;
    int                free;
    mem_seed = ~32'd85528;
    forever begin
      @(negedge clk_i);
      if (rst_ni && mem_req_valid_o) begin
        req_addr = mem_req_addr_o;
        mem_seed = lcg_next(mem_seed);
        repeat (mem_seed[17:16]) @(posedge clk_i);
        @(posedge clk_i);
        #2;
        mem_req_ready_i = 1'b1;
        @(negedge clk_i);
        // handshake happens at the coming edge
        req_count++;
        assert (mem_req_valid_o && mem_req_addr_o == req_addr) else begin
          bus_errs++;
          $display("request dropped or changed its address while waiting for ready");
        end
        assert (mem_req_nc_o == last_nc) else begin
          bus_errs++;
          $display("Fail %0t: mem_req_nc_o got %b expected %b", $time, mem_req_nc_o, last_nc);
        end
        assert (mem_req_addr_o == (last_nc ? {last_addr[31:2], 2'b00}
                                           : {last_addr[31:4], 4'h0})) else begin
          bus_errs++;
          $display("Fail %0t: mem_req_addr_o got %h for fetch %h", $time, mem_req_addr_o,
                   last_addr);
        end
        assert (miss_o == !mem_req_nc_o) else begin
          bus_errs++;
          $display("Fail %0t: miss_o got %b expected %b", $time, miss_o, !mem_req_nc_o);
        end
        if (!mem_req_nc_o) begin
          // first invalid way must be refilled before any valid one
          idx  = mem_req_addr_o[icache_pkg::OFF_W +: icache_pkg::IDX_W];
          free = -1;
          for (int w = icache_pkg::WAYS - 1; w >= 0; w--) begin
            if (!mdl_vld[idx][w]) begin
              free = w;
            end
          end
          assert (free < 0 || int'(mem_req_way_o) == free) else begin
            bus_errs++;
            $display("Fail %0t: mem_req_way_o got %0d expected %0d", $time, mem_req_way_o, free);
          end
          mdl_vld[idx][mem_req_way_o] = 1'b1;
          mdl_tag[idx][mem_req_way_o] = mem_req_addr_o[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];
          way_of[mem_req_addr_o]      = mem_req_way_o;
        end
        @(posedge clk_i);
        #2;
        mem_req_ready_i = 1'b0;
        // fill seen by the cache 2 to 5 edges after the handshake
        mem_seed = lcg_next(mem_seed);
        repeat (mem_seed[17:16] + 1) @(posedge clk_i);
        #2;
        mem_rtrn_valid_i = 1'b1;
        mem_rtrn_type_i  = icache_pkg::RTRN_IFILL;
        mem_rtrn_data_i  = line_data({req_addr[31:4], 4'h0});
        @(posedge clk_i);
        #2;
        mem_rtrn_valid_i = 1'b0;
      end
    end
  end

  //////////////////////////////
  // checker
  //////////////////////////////

  initial begin : response_check
    icache_pkg::addr_t a;
    logic              nc;
    logic              need;
    forever begin
      @(negedge clk_i);
      if (rst_ni) begin
        if (rsp_valid_o) begin
          assert (pend_addr.size() != 0) else begin
            data_errs++;
            $display("response without an accepted fetch at %0t", $time);
          end
          if (pend_addr.size() != 0) begin
            a = pend_addr.pop_front();
            assert (rsp_data_o == mem_word(a)) else begin
              data_errs++;
              $display("Fail %0t: rsp_data_o got %h expected %h (addr %h)", $time,
                       rsp_data_o, mem_word(a), a);
            end
            assert (req_count == pend_reqs[0]) else begin
              bus_errs++;
              $display("Fail %0t: memory request count got %0d expected %0d (addr %h)",
                       $time, req_count, pend_reqs[0], a);
            end
            pend_reqs.pop_front();
          end
        end
        // fetch is accepted at the next edge
        if (req_valid_i && req_ready_o) begin
          nc        = !en_i || req_addr_i[icache_pkg::NC_BIT];
          need      = nc || !line_cached(req_addr_i);
          last_addr = req_addr_i;
          last_nc   = nc;
          pend_addr.push_back(req_addr_i);
          pend_reqs.push_back(req_count + int'(need));
        end
        if (miss_o) begin
          miss_count++;
          assert (mem_req_valid_o && mem_req_ready_i && !mem_req_nc_o) else begin
            bus_errs++;
            $display("miss pulse outside a cacheable request handshake at %0t", $time);
          end
        end
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= 40 * issued + 2000) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout: the cache stopped answering fetches after %0d cycles", cycles);
    $display("ERRORS FOUND");
    $finish;
  end

  //////////////////////////////
  // stimulus tasks
  //////////////////////////////

  task automatic fetch(input icache_pkg::addr_t a);
    req_valid_i = 1'b1;
    req_addr_i  = a;
    issued++;
    do begin
      @(negedge clk_i);
    end while (!req_ready_o);
    @(posedge clk_i);
    #2;
    req_valid_i = 1'b0;
  endtask

  // wait until every accepted fetch is answered and the memory is quiet
  task automatic settle();
    while (pend_addr.size() != 0) begin
      @(posedge clk_i);
    end
    repeat (3) @(posedge clk_i);
    #2;
  endtask

  task automatic flush_cache();
    drop_model_lines();
    flush_i = 1'b1;
    @(posedge clk_i);
    #2;
    flush_i = 1'b0;
  endtask

  task automatic invalidate(input icache_pkg::idx_t idx, input logic all,
                            input icache_pkg::way_t way);
    for (int w = 0; w < icache_pkg::WAYS; w++) begin
      if (all || w == int'(way)) begin
        mdl_vld[idx][w] = 1'b0;
      end
    end
    mem_rtrn_valid_i   = 1'b1;
    mem_rtrn_type_i    = icache_pkg::RTRN_INV;
    mem_rtrn_inv_idx_i = idx;
    mem_rtrn_inv_all_i = all;
    mem_rtrn_inv_way_i = way;
    @(posedge clk_i);
    #2;
    mem_rtrn_valid_i = 1'b0;
  endtask

  task automatic check_traffic(input int r0, input int m0, input int dr, input int dm,
                               input string what);
    assert (req_count - r0 == dr) else begin
      bus_errs++;
      $display("Fail %0t: %s mem_req handshakes got %0d expected %0d", $time, what,
               req_count - r0, dr);
    end
    assert (miss_count - m0 == dm) else begin
      bus_errs++;
      $display("Fail %0t: %s miss_o pulses got %0d expected %0d", $time, what,
               miss_count - m0, dm);
    end
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin : stimulus
    logic [31:0]       stim_seed;
    icache_pkg::addr_t a;
    int                r0, m0;
    rst_ni = 1'b0;
    req_valid_i = 1'b0;
    req_addr_i = '0;
    flush_i = 1'b0;
    en_i = 1'b0;
    mem_req_ready_i = 1'b0;
    mem_rtrn_valid_i = 1'b0;
    mem_rtrn_type_i = icache_pkg::RTRN_IFILL;
    mem_rtrn_data_i = '0;
    mem_rtrn_inv_idx_i = '0;
    mem_rtrn_inv_all_i = 1'b0;
    mem_rtrn_inv_way_i = '0;
    issued = 0;
    req_count = 0;
    miss_count = 0;
    data_errs = 0;
    bus_errs = 0;
    stim_seed = 32'd85528;
    drop_model_lines();
    repeat (2) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    repeat (2) @(posedge clk_i);
    #2;

    // disabled cache, everything goes to memory uncached
    r0 = req_count;
    m0 = miss_count;
    fetch(32'h0000_1230);
    fetch(32'h0000_1234);
    settle();
    check_traffic(r0, m0, 2, 0, "disabled");

    // enable flushes, then one refill serves the whole line
    en_i = 1'b1;
    drop_model_lines();
    r0 = req_count;
    m0 = miss_count;
    fetch(32'h0000_1230);
    fetch(32'h0000_1234);
    fetch(32'h0000_1238);
    fetch(32'h0000_123c);
    settle();
    check_traffic(r0, m0, 1, 1, "miss then hit");

    // i/o space is never cached
    r0 = req_count;
    m0 = miss_count;
    fetch(32'h8000_1234);
    fetch(32'h8000_1238);
    settle();
    check_traffic(r0, m0, 2, 0, "non-cacheable");

    // flush pulse, then disable and enable again
    r0 = req_count;
    m0 = miss_count;
    flush_cache();
    fetch(32'h0000_1234);
    settle();
    en_i = 1'b0;
    repeat (3) @(posedge clk_i);
    #2;
    en_i = 1'b1;
    drop_model_lines();
    fetch(32'h0000_1230);
    settle();
    check_traffic(r0, m0, 2, 2, "flush");

    // two lines in set 3, drop one way, then the whole set
    r0 = req_count;
    m0 = miss_count;
    fetch(32'h0000_4530);
    fetch(32'h0000_1230);
    settle();
    invalidate(4'd3, 1'b0, way_of[32'h0000_1230]);
    fetch(32'h0000_1230);
    fetch(32'h0000_4534);
    settle();
    invalidate(4'd3, 1'b1, '0);
    fetch(32'h0000_1238);
    fetch(32'h0000_4538);
    settle();
    check_traffic(r0, m0, 4, 4, "invalidation");

    // random fetches over six tags in two sets force replacement
    flush_cache();
    for (int n = 0; n < N_RAND; n++) begin
      stim_seed = lcg_next(stim_seed);
      a = icache_pkg::addr_t'(((stim_seed[26:24] % 6) << 8) | (stim_seed[20] << 4)
                              | (stim_seed[22:21] << 2));
      a[icache_pkg::NC_BIT] = (stim_seed[30:28] == 3'd0);
      fetch(a);
      repeat (stim_seed[17:16] % 3) @(posedge clk_i);
      #2;
    end
    settle();

    $display("fetches %0d, memory requests %0d, misses %0d, data errors %0d, traffic errors %0d",
             issued, req_count, miss_count, data_errs, bus_errs);
    if (data_errs == 0 && bus_errs == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== icache.f ====
icache_pkg.sv
icache_sram.sv
icache_repl.sv
icache_hit.sv
icache_ctrl.sv
icache_top.sv
tb_icache.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - icache_pkg.sv
  - icache_sram.sv
  - icache_repl.sv
  - icache_hit.sv
  - icache_ctrl.sv
  - icache_top.sv
  - target: test
    files:
      - tb_icache.sv
